/* Makefile */
# Verilator simulation of the RV32I/Zicsr decoder

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Mdir obj_dir --top-module decoder_tb -f sim.f
	./obj_dir/Vdecoder_tb | tee sim.log
	@! grep -q "TESTS FAILED" sim.log
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim.f */
src/decoder_pkg.sv
src/instr_classifier.sv
src/imm_gen.sv
src/decode_ctrl.sv
src/decoder_top.sv
testbench/tb_clock_gen.sv
testbench/decoder_tb.sv

/* src/decode_ctrl.sv */
//==========================================================================
// Decoder bus control
// Accepts a strobe, registers the decoded result one cycle later and
// returns ack or err. Both drop with the strobe.
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
    input  wire logic                         clk_i,
    input  wire logic                         rst_i,
    input  wire logic                         stb_i,
    input  wire logic                         cyc_i,
    input  wire logic                         illegal_i,
    input  wire decoder_pkg::decoded_t        fields_i,
    input  wire logic [decoder_pkg::XLEN-1:0] imm_i,
    output decoder_pkg::decoded_t             decoded_o,
    output logic                              ack_o,
    output logic                              err_o
);

    logic                  done_q;
    logic                  err_q;
    logic                  accept;
    decoder_pkg::decoded_t merged;
    decoder_pkg::decoded_t result_q;

    assign accept = stb_i && cyc_i && !done_q && !err_q;

    always_comb begin
        merged     = fields_i;
        merged.imm = imm_i;                     // Classifier leaves imm zero
    end

    //======================================================================
    // Done flags and result register
    //======================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            done_q   <= 1'b0;
            err_q    <= 1'b0;
            result_q <= '0;
        end else if (accept) begin
            if (illegal_i) begin
                err_q <= 1'b1;                  // Result keeps last value
            end else begin
                done_q   <= 1'b1;
                result_q <= merged;
            end
        end else if (!stb_i) begin
            done_q <= 1'b0;                     // Requester released strobe
            err_q  <= 1'b0;
        end
    end

    assign ack_o     = done_q && stb_i;
    assign err_o     = err_q && stb_i;
    assign decoded_o = result_q;

    //======================================================================
    // Checks
    //======================================================================
    a_ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(ack_o && err_o));

    // A completion is always preceded by a cycle with the strobe held
    a_done_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
        (ack_o || err_o) |-> $past(stb_i));

endmodule

`default_nettype wire

/* src/decoder_pkg.sv */
//==========================================================================
// RISC-V decoder shared definitions
// Widths, major opcodes, decoded instruction types, immediate formats
// and the registered result word returned on the bus
//==========================================================================
`default_nettype none

package decoder_pkg;

    localparam int XLEN      = 32;      // Instruction and immediate width
    localparam int REG_IDX_W = 5;       // x0..x31

    // Major opcodes, ISA encodings of instr[6:0]
    typedef enum logic [6:0] {
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_SYSTEM   = 7'b1110011,
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_MISC_MEM = 7'b0001111
    } opcode_e;

    //======================================================================
    // Decoded instruction types, numbered from 1 in this order
    //======================================================================
    typedef enum logic [6:0] {
        INSTR_NONE = 7'd0,
        INSTR_BEQ, INSTR_BNE, INSTR_BLT, INSTR_BGE,             // 1..4
        INSTR_BLTU, INSTR_BGEU,                                 // 5..6
        INSTR_LB, INSTR_LH, INSTR_LW, INSTR_LBU, INSTR_LHU,     // 7..11
        INSTR_SB, INSTR_SH, INSTR_SW,                           // 12..14
        INSTR_ADDI, INSTR_SLTI, INSTR_SLTIU, INSTR_XORI,        // 15..18
        INSTR_ORI, INSTR_ANDI,                                  // 19..20
        INSTR_SLLI, INSTR_SRLI, INSTR_SRAI,                     // 21..23
        INSTR_ADD, INSTR_SUB, INSTR_SLL, INSTR_SLT,             // 24..27
        INSTR_SLTU, INSTR_XOR, INSTR_SRL, INSTR_SRA,            // 28..31
        INSTR_OR, INSTR_AND,                                    // 32..33
        INSTR_ECALL, INSTR_EBREAK, INSTR_MRET, INSTR_WFI,       // 34..37
        INSTR_CSRRW, INSTR_CSRRS, INSTR_CSRRC,                  // 38..40
        INSTR_CSRRWI, INSTR_CSRRSI, INSTR_CSRRCI,               // 41..43
        INSTR_LUI, INSTR_AUIPC, INSTR_JAL, INSTR_JALR,          // 44..47
        INSTR_FENCE                                             // 48
    } instr_type_e;

    // Immediate formats
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,                // Zero
        IMM_I    = 3'd1,                // 12 bit, sign-extended
        IMM_S    = 3'd2,                // Store split
        IMM_B    = 3'd3,                // Branch offset, bit 0 zero
        IMM_U    = 3'd4,                // Upper 20 bits
        IMM_J    = 3'd5,                // Jump offset, bit 0 zero
        IMM_CSR  = 3'd6                 // CSR address, zero-extended
    } imm_fmt_e;

    // Decoded result, 55 bits
    typedef struct packed {
        instr_type_e            op_type;
        logic [REG_IDX_W-1:0]   rd;
        logic [REG_IDX_W-1:0]   rs1;
        logic [REG_IDX_W-1:0]   rs2;
        logic [XLEN-1:0]        imm;
        logic                   load_rs;    // rs1/rs2 read from regfile
    } decoded_t;

endpackage

`default_nettype wire

/* src/decoder_top.sv */
//==========================================================================
// RV32I/Zicsr instruction decoder, top level
// Strobe/acknowledge bus in front of the combinational classifier and
// immediate generator, result returned one cycle after accept
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module decoder_top (
    input  wire logic                         clk_i,
    input  wire logic                         rst_i,
    input  wire logic                         stb_i,
    input  wire logic                         cyc_i,
    input  wire logic [decoder_pkg::XLEN-1:0] instr_i,
    output decoder_pkg::decoded_t             decoded_o,
    output logic                              ack_o,
    output logic                              err_o
);

    decoder_pkg::decoded_t       fields;     // imm still zero here
    decoder_pkg::imm_fmt_e       imm_fmt;
    logic [decoder_pkg::XLEN-1:0] imm;
    logic                        illegal;

    instr_classifier instr_classifier_inst (
        .instr_i   (instr_i),
        .fields_o  (fields),
        .imm_fmt_o (imm_fmt),
        .illegal_o (illegal)
    );

    imm_gen imm_gen_inst (
        .instr_i   (instr_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    decode_ctrl decode_ctrl_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stb_i     (stb_i),
        .cyc_i     (cyc_i),
        .illegal_i (illegal),
        .fields_i  (fields),
        .imm_i     (imm),
        .decoded_o (decoded_o),
        .ack_o     (ack_o),
        .err_o     (err_o)
    );

endmodule

`default_nettype wire

/* src/imm_gen.sv */
//==========================================================================
// Immediate generator
// Reorders the instruction bits of each RV32I immediate format and
// extends them to the full word width
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  wire logic [decoder_pkg::XLEN-1:0] instr_i,
    input  wire decoder_pkg::imm_fmt_e        imm_fmt_i,
    output logic [decoder_pkg::XLEN-1:0]      imm_o
);

    logic sign;

    assign sign = instr_i[decoder_pkg::XLEN-1];

    always_comb begin
        case (imm_fmt_i)
            decoder_pkg::IMM_I: begin
                imm_o = {{(decoder_pkg::XLEN-12){sign}}, instr_i[31:20]};
            end
            decoder_pkg::IMM_S: begin
                imm_o = {{(decoder_pkg::XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            end
            decoder_pkg::IMM_B: begin           // imm[12|10:5|4:1|11]
                imm_o = {{(decoder_pkg::XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            decoder_pkg::IMM_U: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            decoder_pkg::IMM_J: begin           // imm[20|10:1|11|19:12]
                imm_o = {{(decoder_pkg::XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            decoder_pkg::IMM_CSR: begin
                imm_o = {{(decoder_pkg::XLEN-12){1'b0}}, instr_i[31:20]};
            end
            default: begin                      // IMM_NONE
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/instr_classifier.sv */
//==========================================================================
// Instruction classifier
// Matches opcode, funct3 and funct7/funct12 of an RV32I/Zicsr word and
// gives the instruction type, the register fields it uses, the
// immediate format and the operand-load flag. Unmatched words are illegal.
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module instr_classifier (
    input  wire logic [decoder_pkg::XLEN-1:0] instr_i,
    output decoder_pkg::decoded_t             fields_o,
    output decoder_pkg::imm_fmt_e             imm_fmt_o,
    output logic                              illegal_o
);

    decoder_pkg::opcode_e     opcode;
    decoder_pkg::instr_type_e op_type;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [11:0]              funct12;
    logic                     use_rd;
    logic                     use_rs1;
    logic                     use_rs2;

    assign opcode  = decoder_pkg::opcode_e'(instr_i[6:0]);
    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign funct12 = instr_i[31:20];

    always_comb begin
        op_type   = decoder_pkg::INSTR_NONE;
        imm_fmt_o = decoder_pkg::IMM_NONE;
        illegal_o = 1'b0;
        use_rd    = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;

        case (opcode)
            decoder_pkg::OPC_BRANCH: begin
                {use_rs1, use_rs2} = 2'b11;
                imm_fmt_o = decoder_pkg::IMM_B;
                case (funct3)
                    3'b000:  op_type = decoder_pkg::INSTR_BEQ;
                    3'b001:  op_type = decoder_pkg::INSTR_BNE;
                    3'b100:  op_type = decoder_pkg::INSTR_BLT;
                    3'b101:  op_type = decoder_pkg::INSTR_BGE;
                    3'b110:  op_type = decoder_pkg::INSTR_BLTU;
                    3'b111:  op_type = decoder_pkg::INSTR_BGEU;
                    default: illegal_o = 1'b1;
                endcase
            end

            decoder_pkg::OPC_LOAD: begin
                {use_rd, use_rs1} = 2'b11;
                imm_fmt_o = decoder_pkg::IMM_I;
                case (funct3)
                    3'b000:  op_type = decoder_pkg::INSTR_LB;
                    3'b001:  op_type = decoder_pkg::INSTR_LH;
                    3'b010:  op_type = decoder_pkg::INSTR_LW;
                    3'b100:  op_type = decoder_pkg::INSTR_LBU;
                    3'b101:  op_type = decoder_pkg::INSTR_LHU;
                    default: illegal_o = 1'b1;
                endcase
            end

            decoder_pkg::OPC_STORE: begin
                {use_rs1, use_rs2} = 2'b11;
                imm_fmt_o = decoder_pkg::IMM_S;
                case (funct3)
                    3'b000:  op_type = decoder_pkg::INSTR_SB;
                    3'b001:  op_type = decoder_pkg::INSTR_SH;
                    3'b010:  op_type = decoder_pkg::INSTR_SW;
                    default: illegal_o = 1'b1;
                endcase
            end

            decoder_pkg::OPC_OP_IMM: begin
                {use_rd, use_rs1} = 2'b11;
                imm_fmt_o = decoder_pkg::IMM_I;
                case (funct3)
                    3'b000: op_type = decoder_pkg::INSTR_ADDI;
                    3'b010: op_type = decoder_pkg::INSTR_SLTI;
                    3'b011: op_type = decoder_pkg::INSTR_SLTIU;
                    3'b100: op_type = decoder_pkg::INSTR_XORI;
                    3'b110: op_type = decoder_pkg::INSTR_ORI;
                    3'b111: op_type = decoder_pkg::INSTR_ANDI;
                    3'b001: begin
                        if (funct7 == 7'b0000000) op_type = decoder_pkg::INSTR_SLLI;
                        else                      illegal_o = 1'b1;
                    end
                    default: begin      // 3'b101, shift right
                        if (funct7 == 7'b0000000)      op_type = decoder_pkg::INSTR_SRLI;
                        else if (funct7 == 7'b0100000) op_type = decoder_pkg::INSTR_SRAI;
                        else                           illegal_o = 1'b1;
                    end
                endcase
            end

            decoder_pkg::OPC_OP: begin
                {use_rd, use_rs1, use_rs2} = 3'b111;
                case ({funct7, funct3})
                    10'b0000000_000: op_type = decoder_pkg::INSTR_ADD;
                    10'b0100000_000: op_type = decoder_pkg::INSTR_SUB;
                    10'b0000000_001: op_type = decoder_pkg::INSTR_SLL;
                    10'b0000000_010: op_type = decoder_pkg::INSTR_SLT;
                    10'b0000000_011: op_type = decoder_pkg::INSTR_SLTU;
                    10'b0000000_100: op_type = decoder_pkg::INSTR_XOR;
                    10'b0000000_101: op_type = decoder_pkg::INSTR_SRL;
                    10'b0100000_101: op_type = decoder_pkg::INSTR_SRA;
                    10'b0000000_110: op_type = decoder_pkg::INSTR_OR;
                    10'b0000000_111: op_type = decoder_pkg::INSTR_AND;
                    default:         illegal_o = 1'b1;
                endcase
            end

            decoder_pkg::OPC_SYSTEM: begin
                if (funct3 == 3'b000) begin     // Privileged, no operands
                    case (funct12)
                        12'h000: op_type = decoder_pkg::INSTR_ECALL;
                        12'h001: op_type = decoder_pkg::INSTR_EBREAK;
                        12'h302: op_type = decoder_pkg::INSTR_MRET;
                        12'h105: op_type = decoder_pkg::INSTR_WFI;
                        default: illegal_o = 1'b1;
                    endcase
                end else begin
                    // rs1 holds the 5 bit zimm for the immediate forms
                    {use_rd, use_rs1} = 2'b11;
                    imm_fmt_o = decoder_pkg::IMM_CSR;
                    case (funct3)
                        3'b001:  op_type = decoder_pkg::INSTR_CSRRW;
                        3'b010:  op_type = decoder_pkg::INSTR_CSRRS;
                        3'b011:  op_type = decoder_pkg::INSTR_CSRRC;
                        3'b101:  op_type = decoder_pkg::INSTR_CSRRWI;
                        3'b110:  op_type = decoder_pkg::INSTR_CSRRSI;
                        3'b111:  op_type = decoder_pkg::INSTR_CSRRCI;
                        default: illegal_o = 1'b1;
                    endcase
                end
            end

            decoder_pkg::OPC_LUI: begin
                use_rd    = 1'b1;
                imm_fmt_o = decoder_pkg::IMM_U;
                op_type   = decoder_pkg::INSTR_LUI;
            end

            decoder_pkg::OPC_AUIPC: begin
                use_rd    = 1'b1;
                imm_fmt_o = decoder_pkg::IMM_U;
                op_type   = decoder_pkg::INSTR_AUIPC;
            end

            decoder_pkg::OPC_JAL: begin
                use_rd    = 1'b1;
                imm_fmt_o = decoder_pkg::IMM_J;
                op_type   = decoder_pkg::INSTR_JAL;
            end

            decoder_pkg::OPC_JALR: begin
                {use_rd, use_rs1} = 2'b11;
                imm_fmt_o = decoder_pkg::IMM_I;
                if (funct3 == 3'b000) op_type = decoder_pkg::INSTR_JALR;
                else                  illegal_o = 1'b1;
            end

            decoder_pkg::OPC_MISC_MEM: begin
                {use_rd, use_rs1} = 2'b11;
                imm_fmt_o = decoder_pkg::IMM_I;     // pred/succ bits
                if (funct3 == 3'b000) op_type = decoder_pkg::INSTR_FENCE;
                else                  illegal_o = 1'b1;
            end

            default: illegal_o = 1'b1;              // Unknown opcode
        endcase

        // Unused fields read as zero, imm is merged downstream
        fields_o.op_type = op_type;
        fields_o.rd      = use_rd  ? instr_i[11:7]  : '0;
        fields_o.rs1     = use_rs1 ? instr_i[19:15] : '0;
        fields_o.rs2     = use_rs2 ? instr_i[24:20] : '0;
        fields_o.imm     = '0;
        fields_o.load_rs = !(op_type inside {
            decoder_pkg::INSTR_NONE,   decoder_pkg::INSTR_LUI,
            decoder_pkg::INSTR_AUIPC,  decoder_pkg::INSTR_JAL,
            decoder_pkg::INSTR_ECALL,  decoder_pkg::INSTR_EBREAK,
            decoder_pkg::INSTR_MRET,   decoder_pkg::INSTR_WFI,
            decoder_pkg::INSTR_CSRRWI, decoder_pkg::INSTR_CSRRSI,
            decoder_pkg::INSTR_CSRRCI});
    end

endmodule

`default_nettype wire

/* testbench/decoder_cases.txt */
# instr(hex) err op_type rd rs1 rs2 imm(hex) load_rs
# Lines with err 1 expect the previous legal result to stay on decoded_o
00000000 1 0 0 0 0 00000000 0
7ff30293 0 15 5 6 0 000007ff 1
002081b3 0 24 3 1 2 00000000 1
02208133 1 0 0 0 0 00000000 0
40c58533 0 25 10 11 12 00000000 1
40325213 0 23 4 4 0 00000403 1
ffc12403 0 9 8 2 0 fffffffc 1
00013083 1 0 0 0 0 00000000 0
00512423 0 14 0 2 5 00000008 1
00208863 0 1 0 1 2 00000010 1
fe41fce3 0 6 0 3 4 fffffff8 1
123452b7 0 44 5 0 0 12345000 0
fffff317 0 45 6 0 0 fffff000 0
ffdff06f 0 46 0 0 0 fffffffc 0
004280e7 0 47 1 5 0 00000004 1
ffffffff 1 0 0 0 0 00000000 0
0ff0000f 0 48 0 0 0 000000ff 1
00000073 0 34 0 0 0 00000000 0
00200073 1 0 0 0 0 00000000 0
30200073 0 36 0 0 0 00000000 0
300110f3 0 38 1 2 0 00000300 1
f142e1f3 0 42 3 5 0 00000f14 0

/* testbench/decoder_tb.sv */
//==========================================================================
// RV32I/Zicsr decoder testbench
// Checks the reset state, replays the case file over the strobe/ack bus
// with a strobe release check per case, then checks a held strobe and
// a strobe with cyc_i low
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module decoder_tb;

    localparam int TIMEOUT = 20;                // Cycles per wait

    logic                                clk, rst, stb, cyc, ack, err;
    logic [decoder_pkg::XLEN-1:0]        instr;
    decoder_pkg::decoded_t               decoded;
    int                                  error_count = 0;
    int                                  test_count  = 0;
    int                                  fail_count  = 0;
    bit                                  timed_out   = 1'b0;
    logic [31:0]                         lfsr        = 32'hba0c_ab3b;
    decoder_pkg::decoded_t               last_good   = '0;  // Expected after an err
    logic [decoder_pkg::XLEN-1:0]        last_instr  = '0;

    tb_clock_gen clock_gen_inst (
        .clk_o (clk),
        .rst_o (rst)
    );

    decoder_top decoder_top_inst (
        .clk_i     (clk),
        .rst_i     (rst),
        .stb_i     (stb),
        .cyc_i     (cyc),
        .instr_i   (instr),
        .decoded_o (decoded),
        .ack_o     (ack),
        .err_o     (err)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    //======================================================================
    // Compare and report
    //======================================================================
    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0d ns: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic field_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("ERROR %0d ns: decoded_o.%s got 0x%0h expected 0x%0h",
                 $time, name, got, exp);
        error_count++;
    endtask

    task automatic check_decoded(input decoder_pkg::decoded_t got,
                                 input decoder_pkg::decoded_t exp);
        if (got.op_type !== exp.op_type)
            field_error("op_type", 32'(got.op_type), 32'(exp.op_type));
        if (got.rd !== exp.rd) field_error("rd", 32'(got.rd), 32'(exp.rd));
        if (got.rs1 !== exp.rs1) field_error("rs1", 32'(got.rs1), 32'(exp.rs1));
        if (got.rs2 !== exp.rs2) field_error("rs2", 32'(got.rs2), 32'(exp.rs2));
        if (got.imm !== exp.imm) field_error("imm", got.imm, exp.imm);
        if (got.load_rs !== exp.load_rs)
            field_error("load_rs", 32'(got.load_rs), 32'(exp.load_rs));
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_count++;
        if (error_count != errors_before) begin
            fail_count++;
            $display("test %0d %s: failed", test_count, name);
        end else begin
            $display("test %0d %s: ok", test_count, name);
        end
    endtask

    //======================================================================
    // Bus sequences driven on the falling edge
    //======================================================================
    task automatic idle_gap();
        logic [1:0] gap;
        lfsr   = lfsr_next(lfsr);
        gap[0] = lfsr[0];
        lfsr   = lfsr_next(lfsr);
        gap[1] = lfsr[0];
        @(negedge clk);
        repeat (gap) @(negedge clk);
    endtask

    task automatic wait_response(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(ack || err) && cycles < TIMEOUT);
        if (!(ack || err)) begin
            $display("Timeout: no ack_o or err_o within %0d cycles of the strobe", TIMEOUT);
            error_count++;
            timed_out = 1'b1;
        end else if (cycles != 1) begin
            $display("Response came %0d cycles after the strobe instead of one", cycles);
            error_count++;
        end
    endtask

    // Flags must drop in the same cycle as the strobe
    task automatic release_strobe();
        stb = 1'b0;
        cyc = 1'b0;
        #1;
        check_flag("ack_o", ack, 1'b0);
        check_flag("err_o", err, 1'b0);
    endtask

    task automatic run_case(input logic [31:0] word, input logic exp_err,
                            input decoder_pkg::decoded_t exp);
        int errors_before;
        int cycles;
        errors_before = error_count;
        idle_gap();
        instr = word;
        stb   = 1'b1;
        cyc   = 1'b1;
        wait_response(cycles);
        check_flag("ack_o", ack, !exp_err);
        check_flag("err_o", err, exp_err);
        if (exp_err) check_decoded(decoded, last_good);    // Result register holds
        else check_decoded(decoded, exp);
        release_strobe();
        if (!exp_err) begin
            last_good  = exp;
            last_instr = word;
        end
        end_test($sformatf("instr 0x%08h", word), errors_before);
    endtask

    task automatic hold_strobe_test();
        int errors_before;
        int cycles;
        errors_before = error_count;
        idle_gap();
        instr = last_instr;
        stb   = 1'b1;
        cyc   = 1'b1;
        wait_response(cycles);
        instr = 32'hffff_ffff;                  // Unknown opcode that must not be taken
        repeat (3) begin
            @(negedge clk);
            check_flag("ack_o", ack, 1'b1);
            check_flag("err_o", err, 1'b0);
            check_decoded(decoded, last_good);
        end
        release_strobe();
        end_test("strobe held after ack", errors_before);
    endtask

    task automatic cyc_low_test();
        int errors_before;
        errors_before = error_count;
        idle_gap();
        instr = 32'hffff_ffff;
        stb   = 1'b1;
        cyc   = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_flag("ack_o", ack, 1'b0);
            check_flag("err_o", err, 1'b0);
            check_decoded(decoded, last_good);
        end
        release_strobe();
        end_test("cyc_i low", errors_before);
    endtask

    //======================================================================
    // Main sequence
    //======================================================================
    initial begin
        int                    fd;
        int                    cycles;
        int                    errors_before;
        string                 line;
        logic [31:0]           word;
        logic [31:0]           imm;
        int                    f_err, f_op, f_rd, f_rs1, f_rs2, f_load;
        decoder_pkg::decoded_t exp;

        stb   = 1'b0;
        cyc   = 1'b0;
        instr = '0;

        errors_before = error_count;
        cycles        = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (rst && cycles < TIMEOUT);
        if (rst) begin
            $display("Timeout: reset was never released");
            error_count++;
            timed_out = 1'b1;
        end
        stb = 1'b1;                             // Strobe without cyc_i shows the done flags
        @(negedge clk);
        check_flag("ack_o", ack, 1'b0);
        check_flag("err_o", err, 1'b0);
        check_decoded(decoded, '0);
        stb = 1'b0;
        end_test("reset state", errors_before);

        fd = $fopen("testbench/decoder_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/decoder_cases.txt");
            error_count++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                if ($sscanf(line, "%h %d %d %d %d %d %h %d", word, f_err, f_op,
                            f_rd, f_rs1, f_rs2, imm, f_load) == 8) begin
                    exp.op_type = decoder_pkg::instr_type_e'(f_op[6:0]);
                    exp.rd      = f_rd[decoder_pkg::REG_IDX_W-1:0];
                    exp.rs1     = f_rs1[decoder_pkg::REG_IDX_W-1:0];
                    exp.rs2     = f_rs2[decoder_pkg::REG_IDX_W-1:0];
                    exp.imm     = imm;
                    exp.load_rs = f_load[0];
                    run_case(word, f_err[0], exp);
                end
            end
            $fclose(fd);
        end

        if (!timed_out) hold_strobe_test();
        if (!timed_out) cyc_low_test();

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 test_count, test_count - fail_count, fail_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
//==========================================================================
// Testbench clock and reset
// 4 ns clock, synchronous reset held for the first 8 rising edges
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;              // 4 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        rst_o <= 1'b0;                          // DUT still sees the 8th edge in reset
    end

endmodule

`default_nettype wire
